/* fe_pkg.sv */
package fe_pkg;

  // ============================================================
  // widths
  // ============================================================
  localparam int VADDR_W    = 32;
  localparam int LINE_B     = 8;  // bytes per fetch line
  localparam int LINE_W     = 64;
  localparam int LINE_OFS_W = $clog2(LINE_B);

  typedef logic [VADDR_W-1:0] vaddr_t;
  typedef logic [LINE_W-1:0]  line_t;

  // ============================================================
  // enums
  // ============================================================
  // real exceptions carry their riscv cause number (medeleg bit)
  typedef enum logic [3:0] {
    ILLEGAL_INST    = 4'd2,
    ECALL_U         = 4'd8,
    ECALL_S         = 4'd9,
    SRET            = 4'd10,
    ECALL_M         = 4'd11,
    INST_PAGE_FAULT = 4'd12,
    SILENT_FLUSH    = 4'd13,
    ANOTHER_FLUSH   = 4'd14,
    MRET            = 4'd15
  } except_cause_t;

  typedef enum logic [1:0] {
    INIT         = 2'd0,
    FETCH_REQ    = 2'd1,
    WAIT_IC_FILL = 2'd2
  } fetch_state_t;

  // ============================================================
  // structs
  // ============================================================
  typedef struct packed {
    logic          valid;
    except_cause_t cause;
    vaddr_t        epc;
  } commit_flush_t;

  typedef struct packed {
    vaddr_t             mtvec;
    vaddr_t             stvec;
    vaddr_t             mepc;
    vaddr_t             sepc;
    logic [VADDR_W-1:0] medeleg;
  } csr_trap_t;

  typedef struct packed {
    logic   valid;
    logic   mispredict;
    logic   taken;
    vaddr_t pc;
    vaddr_t target;
  } br_upd_t;

  typedef struct packed {
    logic   valid;
    vaddr_t vaddr;
  } imem_req_t;

  typedef struct packed {
    logic  valid;
    logic  hit;
    line_t data;
  } imem_resp_t;

  typedef struct packed {
    vaddr_t pc;
    line_t  data;
  } disp_t;

  // clear offset bits down to the line boundary
  function automatic vaddr_t line_align(vaddr_t a);
    return a & ~vaddr_t'(LINE_B - 1);
  endfunction

endpackage

/* fe_redirect.sv */
`timescale 1ns/10ps

module fe_redirect (
  input  fe_pkg::commit_flush_t i_commit,
  input  fe_pkg::csr_trap_t     i_csr,
  input  fe_pkg::br_upd_t       i_br_upd,
  output logic                  o_flush_valid,
  output fe_pkg::vaddr_t        o_flush_vaddr
);

  import fe_pkg::*;

  vaddr_t w_trap_vec;
  vaddr_t w_commit_target;
  logic   w_br_flush;

  // ============================================================
  // commit flush target
  // ============================================================

  // delegated traps go to supervisor vector
  assign w_trap_vec = i_csr.medeleg[i_commit.cause] ? i_csr.stvec : i_csr.mtvec;

  always_comb begin
    case (i_commit.cause)
      SILENT_FLUSH: begin
        w_commit_target = i_commit.epc + vaddr_t'(4);  // resume after the inst
      end
      ANOTHER_FLUSH: begin
        w_commit_target = i_commit.epc;  // refetch same inst
      end
      MRET: begin
        w_commit_target = i_csr.mepc;
      end
      SRET: begin
        w_commit_target = i_csr.sepc;
      end
      ECALL_U, ECALL_S, ECALL_M, INST_PAGE_FAULT, ILLEGAL_INST: begin
        w_commit_target = w_trap_vec;
      end
      default: begin
        w_commit_target = i_csr.mtvec;
      end
    endcase
  end

  // ============================================================
  // branch mispredict and priority
  // ============================================================
  assign w_br_flush = i_br_upd.valid & i_br_upd.mispredict;

  assign o_flush_valid = i_commit.valid | w_br_flush;

  // commit wins over a same-cycle mispredict
  assign o_flush_vaddr = i_commit.valid ? w_commit_target : i_br_upd.target;

endmodule

/* fe_btb.sv */
`timescale 1ns/10ps

module fe_btb #(
  parameter int BTB_ENTRIES = 16
) (
  input  logic            i_clk,
  input  logic            i_reset_n,
  input  logic            i_lookup_valid,
  input  fe_pkg::vaddr_t  i_lookup_vaddr,
  input  fe_pkg::br_upd_t i_br_upd,
  output logic            o_s1_hit,
  output fe_pkg::vaddr_t  o_s1_target
);

  import fe_pkg::*;

  localparam int IDX_W = $clog2(BTB_ENTRIES);
  localparam int TAG_W = VADDR_W - LINE_OFS_W - IDX_W;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    vaddr_t           target;
  } btb_entry_t;

  logic [BTB_ENTRIES-1:0] r_valid;
  btb_entry_t             r_entry [BTB_ENTRIES];

  logic [IDX_W-1:0] w_upd_idx;
  logic [TAG_W-1:0] w_upd_tag;
  logic [IDX_W-1:0] w_lu_idx;
  logic [TAG_W-1:0] w_lu_tag;
  logic             w_lu_hit;

  assign w_upd_idx = i_br_upd.pc[LINE_OFS_W +: IDX_W];
  assign w_upd_tag = i_br_upd.pc[VADDR_W-1 -: TAG_W];
  assign w_lu_idx  = i_lookup_vaddr[LINE_OFS_W +: IDX_W];
  assign w_lu_tag  = i_lookup_vaddr[VADDR_W-1 -: TAG_W];

  // ============================================================
  // update
  // ============================================================
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else if (i_br_upd.valid) begin
      r_valid[w_upd_idx] <= i_br_upd.taken;  // not-taken drops the entry
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_br_upd.valid & i_br_upd.taken) begin
      r_entry[w_upd_idx].tag    <= w_upd_tag;
      r_entry[w_upd_idx].target <= i_br_upd.target;
    end
  end

  // ============================================================
  // lookup registered into s1
  // ============================================================
  assign w_lu_hit = i_lookup_valid & r_valid[w_lu_idx] &
                    (r_entry[w_lu_idx].tag == w_lu_tag);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_s1_hit <= 1'b0;
    end else begin
      o_s1_hit <= w_lu_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    o_s1_target <= line_align(r_entry[w_lu_idx].target);
  end

endmodule

/* fe_fetch_ctrl.sv */
`timescale 1ns/10ps

module fe_fetch_ctrl #(
  parameter fe_pkg::vaddr_t RESET_PC = 32'h8000_0000
) (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_flush_valid,
  input  fe_pkg::vaddr_t     i_flush_vaddr,
  input  logic               i_s1_hit,
  input  fe_pkg::vaddr_t     i_s1_target,
  input  fe_pkg::imem_resp_t i_imem_resp,
  input  logic               i_imem_refill,
  output fe_pkg::imem_req_t  o_imem_req,
  output logic               o_btb_lookup_valid,
  output fe_pkg::vaddr_t     o_btb_lookup_vaddr,
  output logic               o_disp_valid,
  output fe_pkg::disp_t      o_disp
);

  import fe_pkg::*;

  fetch_state_t r_state;
  fetch_state_t w_state_next;

  // s0
  vaddr_t r_pc;  // next sequential line
  vaddr_t w_pc_next;
  vaddr_t w_s0_vaddr;
  logic   w_req_valid;

  // s1, s2
  logic   r_s1_valid;
  vaddr_t r_s1_vaddr;
  logic   r_s2_valid;
  vaddr_t r_s2_vaddr;

  logic w_s1_pred;
  logic w_s2_live;
  logic w_s2_hit;
  logic w_s2_miss;

  // ============================================================
  // s2 response
  // ============================================================
  assign w_s2_live = r_s2_valid & i_imem_resp.valid & ~i_flush_valid;
  assign w_s2_hit  = w_s2_live & i_imem_resp.hit;
  assign w_s2_miss = w_s2_live & ~i_imem_resp.hit;

  assign w_s1_pred = r_s1_valid & i_s1_hit;

  // ============================================================
  // s0 address and state machine
  // ============================================================
  always_comb begin
    if (i_flush_valid) begin
      w_s0_vaddr = line_align(i_flush_vaddr);
    end else if (w_s1_pred) begin
      w_s0_vaddr = i_s1_target;  // already aligned by btb
    end else begin
      w_s0_vaddr = r_pc;
    end
  end

  always_comb begin
    w_state_next = r_state;
    w_req_valid  = 1'b0;
    w_pc_next    = r_pc;
    case (r_state)
      INIT: begin
        w_state_next = FETCH_REQ;
      end
      FETCH_REQ: begin
        if (w_s2_miss) begin
          w_state_next = WAIT_IC_FILL;
          w_pc_next    = r_s2_vaddr;  // park on the missed line
        end else begin
          w_req_valid = 1'b1;
          w_pc_next   = w_s0_vaddr + vaddr_t'(LINE_B);
        end
      end
      WAIT_IC_FILL: begin
        if (i_flush_valid | i_imem_refill) begin
          w_state_next = FETCH_REQ;
          w_req_valid  = 1'b1;
          w_pc_next    = w_s0_vaddr + vaddr_t'(LINE_B);
        end
      end
      default: begin
        w_state_next = INIT;
      end
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= INIT;
      r_pc    <= RESET_PC;
    end else begin
      r_state <= w_state_next;
      r_pc    <= w_pc_next;
    end
  end

  // ============================================================
  // pipeline valids and addresses
  // ============================================================
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid   <= 1'b0;
      r_s2_valid   <= 1'b0;
      o_disp_valid <= 1'b0;
    end else begin
      r_s1_valid   <= w_req_valid;
      r_s2_valid   <= r_s1_valid & ~i_flush_valid & ~w_s2_miss;  // killed as younger
      o_disp_valid <= w_s2_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_vaddr <= w_s0_vaddr;
    r_s2_vaddr <= r_s1_vaddr;
    if (w_s2_hit) begin
      o_disp.pc   <= r_s2_vaddr;
      o_disp.data <= i_imem_resp.data;
    end
  end

  assign o_imem_req.valid   = w_req_valid;
  assign o_imem_req.vaddr   = w_s0_vaddr;
  assign o_btb_lookup_valid = w_req_valid;
  assign o_btb_lookup_vaddr = w_s0_vaddr;

endmodule

/* fe_frontend.sv */
`timescale 1ns/10ps

module fe_frontend #(
  parameter int             BTB_ENTRIES = 16,
  parameter fe_pkg::vaddr_t RESET_PC    = 32'h8000_0000
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  fe_pkg::commit_flush_t i_commit,
  input  fe_pkg::csr_trap_t     i_csr,
  input  fe_pkg::br_upd_t       i_br_upd,
  input  fe_pkg::imem_resp_t    i_imem_resp,
  input  logic                  i_imem_refill,
  output fe_pkg::imem_req_t     o_imem_req,
  output logic                  o_disp_valid,
  output fe_pkg::disp_t         o_disp
);

  import fe_pkg::*;

  logic   w_flush_valid;
  vaddr_t w_flush_vaddr;
  logic   w_btb_lookup_valid;
  vaddr_t w_btb_lookup_vaddr;
  logic   w_s1_hit;
  vaddr_t w_s1_target;

  fe_redirect u_redirect (
    .i_commit      (i_commit),
    .i_csr         (i_csr),
    .i_br_upd      (i_br_upd),
    .o_flush_valid (w_flush_valid),
    .o_flush_vaddr (w_flush_vaddr)
  );

  fe_btb #(
    .BTB_ENTRIES (BTB_ENTRIES)
  ) u_btb (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_lookup_valid (w_btb_lookup_valid),
    .i_lookup_vaddr (w_btb_lookup_vaddr),
    .i_br_upd       (i_br_upd),
    .o_s1_hit       (w_s1_hit),
    .o_s1_target    (w_s1_target)
  );

  fe_fetch_ctrl #(
    .RESET_PC (RESET_PC)
  ) u_fetch_ctrl (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_flush_valid      (w_flush_valid),
    .i_flush_vaddr      (w_flush_vaddr),
    .i_s1_hit           (w_s1_hit),
    .i_s1_target        (w_s1_target),
    .i_imem_resp        (i_imem_resp),
    .i_imem_refill      (i_imem_refill),
    .o_imem_req         (o_imem_req),
    .o_btb_lookup_valid (w_btb_lookup_valid),
    .o_btb_lookup_vaddr (w_btb_lookup_vaddr),
    .o_disp_valid       (o_disp_valid),
    .o_disp             (o_disp)
  );

endmodule

/* tb_frontend.sv */
`timescale 1ns/10ps

module tb_frontend;

  import fe_pkg::*;

  localparam vaddr_t RESET_PC       = 32'h8000_0000;
  localparam int     TIMEOUT_CYCLES = 2000;

  logic          i_clk;
  logic          i_reset_n;
  commit_flush_t commit;
  csr_trap_t     csr;
  br_upd_t       br_upd;
  imem_resp_t    imem_resp;
  logic          imem_refill;
  imem_req_t     imem_req;
  logic          disp_valid;
  disp_t         disp;

  integer     seed = 32'h8ddc4333;
  int         errors = 0;
  int         cycle = 0;
  int         flush_cycle = 0;
  int         disp_count = 0;
  logic       check_gap = 1'b0;
  vaddr_t     exp_pc = RESET_PC;
  disp_t      exp_disp;
  vaddr_t     btb_model [vaddr_t];  // line address -> branch target
  imem_resp_t mem_stage = '0;
  logic       miss_arm = 1'b0;
  vaddr_t     miss_line = '0;

  fe_frontend #(
    .BTB_ENTRIES (16),
    .RESET_PC    (RESET_PC)
  ) UUT (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_commit      (commit),
    .i_csr         (csr),
    .i_br_upd      (br_upd),
    .i_imem_resp   (imem_resp),
    .i_imem_refill (imem_refill),
    .o_imem_req    (imem_req),
    .o_disp_valid  (disp_valid),
    .o_disp        (disp)
  );

  initial i_clk = 1'b0;
  always #5 i_clk = ~i_clk;

  // ============================================================
  // reference rules and checks
  // ============================================================
  function automatic vaddr_t align_line(vaddr_t a);
    return a & ~(vaddr_t'(LINE_B) - vaddr_t'(1));
  endfunction

  function automatic line_t line_data(vaddr_t a);
    return {~a, a};  // inverse above, address below
  endfunction

  function automatic vaddr_t flush_target(commit_flush_t c, csr_trap_t s, br_upd_t b);
    vaddr_t t;
    if (!c.valid) begin
      t = b.target;
    end else begin
      case (c.cause)
        SILENT_FLUSH:  t = c.epc + 32'd4;
        ANOTHER_FLUSH: t = c.epc;
        MRET:          t = s.mepc;
        SRET:          t = s.sepc;
        default:       t = s.medeleg[int'(c.cause)] ? s.stvec : s.mtvec;
      endcase
    end
    return align_line(t);
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("Mismatch at %0t ns: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_disp(input disp_t got, input disp_t want);
    if (got !== want) begin
      report_mismatch($sformatf("dispatch pc %h data %h, expected pc %h data %h",
                                got.pc, got.data, want.pc, want.data));
    end
  endtask

  task automatic compare_req(input imem_req_t got, input imem_req_t want);
    if (got.valid !== want.valid || (want.valid && got.vaddr !== want.vaddr)) begin
      report_mismatch($sformatf("request valid %b addr %h, expected valid %b addr %h",
                                got.valid, got.vaddr, want.valid, want.vaddr));
    end
  endtask

  // ============================================================
  // memory model and dispatch monitor
  // ============================================================
  always @(posedge i_clk) begin
    imem_resp            <= mem_stage;  // two cycles after the request
    mem_stage.valid      <= imem_req.valid;
    mem_stage.hit        <= !(miss_arm && imem_req.vaddr == miss_line);
    mem_stage.data       <= line_data(imem_req.vaddr);
    if (imem_req.valid && miss_arm && imem_req.vaddr == miss_line) begin
      miss_arm <= 1'b0;  // one miss only
    end
  end

  always @(posedge i_clk) begin
    cycle++;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: no finish after %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $fatal(1, "run stopped by timeout");
    end
    if (disp_valid) begin
      exp_disp.pc   = exp_pc;
      exp_disp.data = line_data(exp_pc);
      compare_disp(disp, exp_disp);
      if (check_gap && cycle != flush_cycle + 3) begin
        report_mismatch($sformatf("first dispatch %0d cycles after flush",
                                  cycle - flush_cycle));
      end
      check_gap = 1'b0;
      disp_count++;
      if (btb_model.exists(exp_pc)) exp_pc = align_line(btb_model[exp_pc]);
      else exp_pc = exp_pc + vaddr_t'(LINE_B);
    end
    if (br_upd.valid) begin
      if (br_upd.taken) btb_model[align_line(br_upd.pc)] = br_upd.target;
      else if (btb_model.exists(align_line(br_upd.pc))) btb_model.delete(align_line(br_upd.pc));
    end
    if (commit.valid || (br_upd.valid && br_upd.mispredict)) begin
      exp_pc      = flush_target(commit, csr, br_upd);  // older lines are killed
      flush_cycle = cycle;
      check_gap   = 1'b1;
    end
  end

  // ============================================================
  // stimulus tasks
  // ============================================================
  task automatic wait_disp(input int n);
    int target;
    target = disp_count + n;
    while (disp_count < target) @(negedge i_clk);
  endtask

  task automatic pulse_flush(input commit_flush_t c, input br_upd_t b);
    @(posedge i_clk);
    commit <= c;
    br_upd <= b;
    @(posedge i_clk);
    commit <= '0;
    br_upd <= '0;
  endtask

  task automatic wait_miss();
    do @(posedge i_clk); while (!(imem_resp.valid && !imem_resp.hit));
  endtask

  task automatic sequential_after_reset();
    repeat (4) @(posedge i_clk);
    i_reset_n <= 1'b1;
    @(posedge i_clk);
    compare_req(imem_req, '0);  // INIT cycle
    @(posedge i_clk);
    compare_req(imem_req, '{valid: 1'b1, vaddr: RESET_PC});
    wait_disp(6);
  endtask

  task automatic btb_steering();
    vaddr_t l;
    vaddr_t t;
    l = align_line(vaddr_t'($random(seed)));
    t = l + 32'h1000;
    pulse_flush('0, '{valid: 1'b1, mispredict: 1'b1, taken: 1'b1, pc: l + 32'd4,
                      target: t + 32'd4});
    wait_disp(3);
    pulse_flush('{valid: 1'b1, cause: ANOTHER_FLUSH, epc: l - 32'd16}, '0);
    wait_disp(6);  // l-16, l-8, l, then t stream
    pulse_flush('0, '{valid: 1'b1, mispredict: 1'b1, taken: 1'b0, pc: l,
                      target: l - 32'd16});
    wait_disp(5);
  endtask

  task automatic commit_traps();
    except_cause_t causes [9];
    causes = '{SILENT_FLUSH, ANOTHER_FLUSH, MRET, SRET, ECALL_U, ECALL_S, ECALL_M,
               INST_PAGE_FAULT, ILLEGAL_INST};
    @(posedge i_clk);
    csr.mtvec <= vaddr_t'($random(seed));
    csr.stvec <= vaddr_t'($random(seed));
    csr.mepc  <= vaddr_t'($random(seed));
    csr.sepc  <= vaddr_t'($random(seed));
    foreach (causes[i]) begin
      @(posedge i_clk);
      csr.medeleg <= $random(seed);
      pulse_flush('{valid: 1'b1, cause: causes[i], epc: vaddr_t'($random(seed)) & ~32'd3},
                  '0);
      wait_disp(3);
    end
  endtask

  task automatic mispredict_priority();
    pulse_flush('0, '{valid: 1'b1, mispredict: 1'b1, taken: 1'b0,
                      pc: vaddr_t'($random(seed)), target: vaddr_t'($random(seed))});
    wait_disp(3);
    // commit and mispredict together
    pulse_flush('{valid: 1'b1, cause: ANOTHER_FLUSH, epc: vaddr_t'($random(seed))},
                '{valid: 1'b1, mispredict: 1'b1, taken: 1'b0,
                  pc: vaddr_t'($random(seed)), target: vaddr_t'($random(seed))});
    wait_disp(3);
  endtask

  task automatic miss_and_refill();
    vaddr_t m;
    wait_disp(1);
    m = exp_pc + 32'd40;  // not requested yet
    miss_line <= m;
    miss_arm  <= 1'b1;
    wait_miss();
    repeat (4) begin
      @(posedge i_clk);
      compare_req(imem_req, '0);
      if (disp_valid) report_mismatch("dispatch while waiting for refill");
    end
    imem_refill <= 1'b1;
    @(posedge i_clk);
    compare_req(imem_req, '{valid: 1'b1, vaddr: m});
    imem_refill <= 1'b0;
    wait_disp(4);
    // flush during the wait
    wait_disp(1);
    miss_line <= exp_pc + 32'd40;
    miss_arm  <= 1'b1;
    wait_miss();
    repeat (2) @(posedge i_clk);
    pulse_flush('{valid: 1'b1, cause: ANOTHER_FLUSH, epc: vaddr_t'($random(seed))}, '0);
    wait_disp(3);
  endtask

  // ============================================================
  // main
  // ============================================================
  initial begin
    i_reset_n   = 1'b0;
    commit      = '0;
    csr         = '0;
    br_upd      = '0;
    imem_resp   = '0;
    imem_refill = 1'b0;
    sequential_after_reset();
    btb_steering();
    commit_traps();
    mispredict_priority();
    miss_and_refill();
    repeat (2) @(posedge i_clk);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* files.f */
fe_pkg.sv
fe_redirect.sv
fe_btb.sv
fe_fetch_ctrl.sv
fe_frontend.sv
tb_frontend.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_frontend
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= NO ERRORS

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
